//--- Makefile
VERILATOR ?= verilator
TOP       ?= sdiTb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@grep -q "Verification passed" $(LOG) || { echo "no result in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- files.f
rtl/sdiPkg.sv
rtl/sdiRegPkg.sv
rtl/symbolFifoIf.sv
rtl/sdiRegs.sv
rtl/symbolFifo.sv
rtl/byteSerializer.sv
rtl/baudTimer.sv
rtl/uartTx.sv
rtl/sdiTop.sv
verification/clockGen.sv
verification/sdiTb.sv

//--- rtl/baudTimer.sv
`timescale 1ns/100ps

module baudTimer (
    input  logic            clk,
    input  logic            fifoDone,
    input  sdiPkg::baudDivT baudDiv,
    output logic            baudTick
);

    sdiPkg::baudDivT count;

    // Tick period is baudDiv + 1 clocks.
    always_ff @(posedge clk or posedge fifoDone) begin
        if (fifoDone) begin
            count    <= '0;
            baudTick <= 1'b0;
        end else if (count == '0) begin
            count    <= baudDiv;                // Reload.
            baudTick <= 1'b1;
        end else begin
            count    <= count - 1'b1;
            baudTick <= 1'b0;
        end
    end

endmodule

//--- rtl/byteSerializer.sv
`timescale 1ns/100ps

module byteSerializer (
    input  logic             clk,
    input  logic             fifoDone,
    input  logic             captureEn,
    symbolFifoIf.reader      link,
    input  logic             byteNeeded,
    output sdiPkg::uartByteT byteData,
    output logic             byteAvailable
);

    sdiPkg::serialStateT state;

    // Each byte is held until byteNeeded falls and rises again.
    always_ff @(posedge clk or posedge fifoDone) begin
        if (fifoDone) begin
            state         <= sdiPkg::stIdle;
            byteAvailable <= 1'b0;
            byteData      <= '0;
            link.readEn   <= 1'b0;
        end else begin
            link.readEn   <= 1'b0;
            byteAvailable <= 1'b0;                      // Offered for one clock.
            case (state)
                sdiPkg::stIdle: begin
                    if (!captureEn && !link.empty && byteNeeded) begin
                        state         <= sdiPkg::stIHighSend;
                        byteAvailable <= 1'b1;
                        byteData      <= link.head.i[15:8];
                    end
                end
                sdiPkg::stIHighSend: begin
                    if (!byteNeeded) state <= sdiPkg::stIHighWait;
                end
                sdiPkg::stIHighWait: begin
                    if (byteNeeded) begin
                        state         <= sdiPkg::stILowSend;
                        byteAvailable <= 1'b1;
                        byteData      <= link.head.i[7:0];
                    end
                end
                sdiPkg::stILowSend: begin
                    if (!byteNeeded) state <= sdiPkg::stILowWait;
                end
                sdiPkg::stILowWait: begin
                    if (byteNeeded) begin
                        state         <= sdiPkg::stQHighSend;
                        byteAvailable <= 1'b1;
                        byteData      <= link.head.q[15:8];
                    end
                end
                sdiPkg::stQHighSend: begin
                    if (!byteNeeded) state <= sdiPkg::stQHighWait;
                end
                sdiPkg::stQHighWait: begin
                    if (byteNeeded) begin
                        state         <= sdiPkg::stQLowSend;
                        byteAvailable <= 1'b1;
                        byteData      <= link.head.q[7:0];
                        link.readEn   <= 1'b1;          // Pop with the last byte.
                    end
                end
                sdiPkg::stQLowSend: begin
                    if (!byteNeeded) state <= sdiPkg::stQLowWait;
                end
                sdiPkg::stQLowWait: begin
                    if (link.empty) begin
                        state <= sdiPkg::stIdle;
                    end else if (byteNeeded) begin
                        state         <= sdiPkg::stIHighSend;
                        byteAvailable <= 1'b1;
                        byteData      <= link.head.i[15:8];
                    end
                end
                default: begin
                    state <= sdiPkg::stIdle;
                end
            endcase
        end
    end

endmodule

//--- rtl/sdiPkg.sv
package sdiPkg;

    typedef logic [17:0] sampleT;        // Raw converter sample.
    typedef logic [15:0] symbolT;        // Upper 16 bits of a sample.
    typedef logic [7:0]  uartByteT;
    typedef logic [15:0] baudDivT;

    typedef struct packed {
        symbolT i;                       // Sent first.
        symbolT q;
    } symbolPairT;

    // Neighbouring states differ in one bit.
    typedef enum logic [3:0] {
        stIdle      = 4'b0000,
        stIHighSend = 4'b0001,
        stIHighWait = 4'b0011,
        stILowSend  = 4'b0010,
        stILowWait  = 4'b0110,
        stQHighSend = 4'b0111,
        stQHighWait = 4'b0101,
        stQLowSend  = 4'b0100,
        stQLowWait  = 4'b1100
    } serialStateT;

endpackage

//--- rtl/sdiRegPkg.sv
package sdiRegPkg;

    //////////////////////////////////////////////////////////////////////
    // Register map
    //////////////////////////////////////////////////////////////////////

    localparam logic [11:0] controlAddr = 12'h000;
    localparam logic [11:0] statusAddr  = 12'h004;
    localparam logic [11:0] baudAddr    = 12'h008;

    //////////////////////////////////////////////////////////////////////
    // Field positions
    //////////////////////////////////////////////////////////////////////

    localparam int controlArmBit      = 0;
    localparam int statusEmptyBit     = 0;
    localparam int statusCapturingBit = 1;

    localparam logic [31:0] unmappedReadValue = 32'h0000_0000;

endpackage

//--- rtl/sdiRegs.sv
`timescale 1ns/100ps

module sdiRegs (
    input  logic            clk,
    input  logic            fifoDone,
    input  logic [11:0]     addr,
    input  logic [31:0]     dataIn,
    input  logic [3:0]      byteWrite,
    input  logic            full,
    input  logic            empty,
    output logic [31:0]     dataOut,
    output sdiPkg::baudDivT baudDiv,
    output logic            captureEn
);

    logic captureArm;
    logic armDelay;

    always_ff @(posedge clk or posedge fifoDone) begin
        if (fifoDone) begin
            baudDiv    <= '0;
            captureArm <= 1'b0;
            armDelay   <= 1'b0;
            captureEn  <= 1'b0;
        end else begin
            if (addr == sdiRegPkg::baudAddr) begin
                if (byteWrite[0]) baudDiv[7:0]  <= dataIn[7:0];
                if (byteWrite[1]) baudDiv[15:8] <= dataIn[15:8];
            end
            if (full) begin
                captureArm <= 1'b0;                     // Stops on a full FIFO.
            end else if (addr == sdiRegPkg::controlAddr && byteWrite[0]) begin
                captureArm <= dataIn[sdiRegPkg::controlArmBit];
            end
            armDelay  <= captureArm && !full;
            captureEn <= armDelay && !full;
        end
    end

    always_comb begin
        dataOut = sdiRegPkg::unmappedReadValue;
        case (addr)
            sdiRegPkg::statusAddr: begin
                dataOut = '0;
                dataOut[sdiRegPkg::statusEmptyBit]     = empty;
                dataOut[sdiRegPkg::statusCapturingBit] = captureArm || captureEn;
            end
            sdiRegPkg::baudAddr: dataOut = {16'h0000, baudDiv};
            default:             dataOut = sdiRegPkg::unmappedReadValue;
        endcase
    end

endmodule

//--- rtl/sdiTop.sv
`timescale 1ns/100ps

module sdiTop #(
    parameter int fifoDepth = 16
) (
    input  logic           clk,
    input  logic           fifoDone,
    input  logic [11:0]    addr,
    input  logic [31:0]    dataIn,
    input  logic [3:0]     byteWrite,
    input  logic           symEn,
    input  sdiPkg::sampleT iSample,
    input  sdiPkg::sampleT qSample,
    output logic [31:0]    dataOut,
    output logic           serialOut
);

    sdiPkg::baudDivT    baudDiv;
    sdiPkg::symbolPairT symbolPair;
    sdiPkg::uartByteT   byteData;
    logic               captureEn;
    logic               byteAvailable;
    logic               byteNeeded;
    logic               baudTick;

    symbolFifoIf fifoLink ();

    assign symbolPair = {iSample[17:2], qSample[17:2]};     // Keep upper 16 bits.

    sdiRegs i_sdiRegs (
        .clk(clk), .fifoDone(fifoDone),
        .addr(addr), .dataIn(dataIn), .byteWrite(byteWrite),
        .full(fifoLink.full), .empty(fifoLink.empty),
        .dataOut(dataOut), .baudDiv(baudDiv), .captureEn(captureEn)
    );

    symbolFifo #(.fifoDepth(fifoDepth)) i_symbolFifo (
        .clk(clk), .fifoDone(fifoDone),
        .writeEn(symEn && captureEn), .din(symbolPair),
        .link(fifoLink.writer)
    );

    byteSerializer i_byteSerializer (
        .clk(clk), .fifoDone(fifoDone), .captureEn(captureEn),
        .link(fifoLink.reader), .byteNeeded(byteNeeded),
        .byteData(byteData), .byteAvailable(byteAvailable)
    );

    baudTimer i_baudTimer (
        .clk(clk), .fifoDone(fifoDone), .baudDiv(baudDiv), .baudTick(baudTick)
    );

    uartTx i_uartTx (
        .clk(clk), .fifoDone(fifoDone), .baudTick(baudTick),
        .byteData(byteData), .byteAvailable(byteAvailable),
        .byteNeeded(byteNeeded), .serialOut(serialOut)
    );

endmodule

//--- rtl/symbolFifo.sv
`timescale 1ns/100ps

module symbolFifo #(
    parameter int fifoDepth = 16
) (
    input  logic               clk,
    input  logic               fifoDone,
    input  logic               writeEn,
    input  sdiPkg::symbolPairT din,
    symbolFifoIf.writer        link
);

    localparam int addrWidth = $clog2(fifoDepth);

    sdiPkg::symbolPairT mem [fifoDepth];

    logic [addrWidth:0] wrPtr;                  // Extra bit tells full from empty.
    logic [addrWidth:0] rdPtr;
    logic               doWrite;
    logic               doRead;

    assign link.empty = (wrPtr == rdPtr);
    assign link.full  = (wrPtr[addrWidth-1:0] == rdPtr[addrWidth-1:0]) &&
                        (wrPtr[addrWidth] != rdPtr[addrWidth]);
    assign link.head  = mem[rdPtr[addrWidth-1:0]];

    assign doWrite = writeEn && !link.full;     // Extra symbols are dropped.
    assign doRead  = link.readEn && !link.empty;

    //////////////////////////////////////////////////////////////////////
    // Pointers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge fifoDone) begin
        if (fifoDone) begin
            wrPtr <= '0;
            rdPtr <= '0;
        end else begin
            if (doWrite) wrPtr <= wrPtr + 1'b1;
            if (doRead)  rdPtr <= rdPtr + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (doWrite) begin
            mem[wrPtr[addrWidth-1:0]] <= din;
        end
    end

endmodule

//--- rtl/symbolFifoIf.sv
`timescale 1ns/100ps

interface symbolFifoIf;

    logic               empty;
    logic               full;
    sdiPkg::symbolPairT head;           // Front entry, show-ahead.
    logic               readEn;         // One-cycle pop.

    modport writer (
        output empty,
        output full,
        output head,
        input  readEn
    );

    modport reader (
        input  empty,
        input  head,
        output readEn
    );

endinterface

//--- rtl/uartTx.sv
`timescale 1ns/100ps

module uartTx (
    input  logic             clk,
    input  logic             fifoDone,
    input  logic             baudTick,
    input  sdiPkg::uartByteT byteData,
    input  logic             byteAvailable,
    output logic             byteNeeded,
    output logic             serialOut
);

    logic [9:0] frame;                          // Stop, data, start.
    logic [3:0] bitCount;

    // Eleventh tick closes the stop bit.
    assign byteNeeded = (bitCount == 4'd0);

    always_ff @(posedge clk or posedge fifoDone) begin
        if (fifoDone) begin
            frame     <= '1;
            bitCount  <= '0;
            serialOut <= 1'b1;                  // Line idles high.
        end else if (byteNeeded) begin
            if (byteAvailable) begin
                frame    <= {1'b1, byteData, 1'b0};
                bitCount <= 4'd11;
            end
        end else if (baudTick) begin
            serialOut <= frame[0];
            frame     <= {1'b1, frame[9:1]};
            bitCount  <= bitCount - 1'b1;
        end
    end

endmodule

//--- verification/clockGen.sv
`timescale 1ns/100ps

module clockGen #(
    parameter realtime halfPeriod = 20ns        // 40 ns period.
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(halfPeriod) clk = ~clk;
    end

endmodule

//--- verification/sdiTb.sv
`timescale 1ns/100ps

module sdiTb;

    localparam int fifoDepth   = 16;
    localparam int resetCycles = 16;
    localparam int captures    = 2;

    logic               clk;
    logic               fifoDone;
    logic [11:0]        addr;
    logic [31:0]        dataIn;
    logic [3:0]         byteWrite;
    logic               symEn;
    sdiPkg::sampleT     iSample;
    sdiPkg::sampleT     qSample;
    logic [31:0]        dataOut;
    logic               serialOut;

    int                 seed;
    int                 vecFile;
    sdiPkg::baudDivT    capDiv;
    int                 capCount;
    sdiPkg::sampleT     iList[$];
    sdiPkg::sampleT     qList[$];
    sdiPkg::uartByteT   expList[$];

    clockGen i_clockGen (.clk(clk));

    sdiTop #(.fifoDepth(fifoDepth)) i_sdiTop (
        .clk(clk), .fifoDone(fifoDone),
        .addr(addr), .dataIn(dataIn), .byteWrite(byteWrite),
        .symEn(symEn), .iSample(iSample), .qSample(qSample),
        .dataOut(dataOut), .serialOut(serialOut)
    );

    //////////////////////////////////////////////////////////////////////
    // Error handling and compares
    //////////////////////////////////////////////////////////////////////

    task automatic stopRun(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkWord(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            stopRun($sformatf("mismatch at %0t: %s read 0x%08h, expected 0x%08h",
                              $time, what, got, exp));
        end
    endtask

    task automatic checkByte(input sdiPkg::uartByteT got, input sdiPkg::uartByteT exp,
                             input int index);
        if (got !== exp) begin
            stopRun($sformatf("mismatch at %0t: line byte %0d is 0x%02h, expected 0x%02h",
                              $time, index, got, exp));
        end
    endtask

    task automatic checkBaud(input sdiPkg::baudDivT got, input sdiPkg::baudDivT exp);
        if (got !== exp) begin
            stopRun($sformatf("mismatch at %0t: baud divisor read 0x%04h, expected 0x%04h",
                              $time, got, exp));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Vector file
    //////////////////////////////////////////////////////////////////////

    task automatic nextDataLine(output string line);
        int  n;
        logic found;
        found = 1'b0;
        line  = "";
        while (!found) begin
            if ($feof(vecFile)) stopRun("vector file ended before all captures were read");
            n = $fgets(line, vecFile);
            if (n > 0 && line.len() > 1 && line[0] != "#") found = 1'b1;
        end
    endtask

    task automatic readCapture();
        string          line;
        int             n;
        logic [31:0]    a, b, c0, c1, c2, c3;
        sdiPkg::symbolT iSym;
        sdiPkg::symbolT qSym;
        iList.delete();
        qList.delete();
        expList.delete();
        nextDataLine(line);
        n = $sscanf(line, "%h %d", a, capCount);
        if (n != 2) stopRun("capture header in the vector file cannot be parsed");
        capDiv = a[15:0];
        if (capCount <= fifoDepth) stopRun("capture has no more symbols than the FIFO depth");
        for (int k = 0; k < capCount; k++) begin
            nextDataLine(line);
            n = $sscanf(line, "%h %h %h %h %h %h", a, b, c0, c1, c2, c3);
            if (n != 6) stopRun("symbol line in the vector file cannot be parsed");
            iSym = a[17:2];                     // Upper 16 bits.
            qSym = b[17:2];
            if ({c0[7:0], c1[7:0], c2[7:0], c3[7:0]} !== {iSym, qSym}) begin
                stopRun("expected bytes in the vector file do not match their samples");
            end
            iList.push_back(a[17:0]);
            qList.push_back(b[17:0]);
            expList.push_back(c0[7:0]);
            expList.push_back(c1[7:0]);
            expList.push_back(c2[7:0]);
            expList.push_back(c3[7:0]);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Bus, strobes and line decode
    //////////////////////////////////////////////////////////////////////

    task automatic hostWrite(input logic [11:0] a, input logic [31:0] d, input logic [3:0] lanes);
        @(posedge clk);
        addr      <= a;
        dataIn    <= d;
        byteWrite <= lanes;
        @(posedge clk);
        byteWrite <= '0;
    endtask

    task automatic hostRead(input logic [11:0] a, output logic [31:0] d);
        @(posedge clk);
        addr <= a;
        @(negedge clk);
        d = dataOut;                            // Combinational read.
    endtask

    task automatic driveSymbols();
        int gap;
        for (int k = 0; k < capCount; k++) begin
            gap = $random(seed) & 3;
            repeat (gap) @(posedge clk);
            @(posedge clk);
            symEn   <= 1'b1;
            iSample <= iList[k];
            qSample <= qList[k];
            @(posedge clk);
            symEn   <= 1'b0;
        end
    endtask

    task automatic waitCaptureDone();
        int waited;
        waited = 0;
        @(posedge clk);
        addr <= sdiRegPkg::statusAddr;
        @(negedge clk);
        while (dataOut[sdiRegPkg::statusCapturingBit] !== 1'b0) begin
            waited++;
            if (waited > 5000) stopRun("timeout waiting for the capturing bit to clear");
            @(negedge clk);
        end
    endtask

    // Every sample of a bit must agree.
    task automatic decodeByte(input int bitClocks, output sdiPkg::uartByteT value);
        logic [9:0] bits;
        logic       level;
        int         waited;
        waited = 0;
        @(negedge clk);
        while (serialOut !== 1'b0) begin
            waited++;
            if (waited > 40 * bitClocks + 400) stopRun("timeout waiting for a start bit");
            @(negedge clk);
        end
        for (int j = 0; j < 10; j++) begin
            if (j > 0) @(negedge clk);
            level = serialOut;
            for (int s = 1; s < bitClocks; s++) begin
                @(negedge clk);
                if (serialOut !== level) begin
                    stopRun($sformatf("mismatch at %0t: frame bit %0d shorter than %0d clocks",
                                      $time, j, bitClocks));
                end
            end
            bits[j] = level;
        end
        if (bits[0] !== 1'b0 || bits[9] !== 1'b1) begin
            stopRun($sformatf("mismatch at %0t: bad start or stop bit", $time));
        end
        value = bits[8:1];                      // LSB first.
    endtask

    task automatic checkLineIdle(input int bitClocks);
        repeat (20 * bitClocks) begin
            @(negedge clk);
            if (serialOut !== 1'b1) begin
                stopRun($sformatf("mismatch at %0t: data after %0d pairs", $time, fifoDepth));
            end
        end
    endtask

    task automatic runCapture();
        logic [31:0]      word;
        logic [31:0]      idleStatus;
        logic [31:0]      armedStatus;
        sdiPkg::uartByteT got;
        int               bitClocks;
        readCapture();
        bitClocks = int'(capDiv) + 1;
        idleStatus = '0;
        idleStatus[sdiRegPkg::statusEmptyBit] = 1'b1;
        armedStatus = idleStatus;
        armedStatus[sdiRegPkg::statusCapturingBit] = 1'b1;
        hostWrite(sdiRegPkg::baudAddr, {16'hFFFF, 8'hEE, capDiv[7:0]}, 4'b0001);
        hostWrite(sdiRegPkg::baudAddr, {16'hFFFF, capDiv[15:8], 8'h55}, 4'b0010);
        hostRead(sdiRegPkg::baudAddr, word);
        checkBaud(word[15:0], capDiv);
        hostWrite(sdiRegPkg::controlAddr, 32'h0000_0001, 4'b0001);
        hostRead(sdiRegPkg::statusAddr, word);
        checkWord(word, armedStatus, "status after arming");
        repeat (2) @(posedge clk);              // captureEn follows the arm bit.
        fork
            begin
                driveSymbols();
                waitCaptureDone();
            end
            begin
                for (int b = 0; b < 4 * fifoDepth; b++) begin
                    decodeByte(bitClocks, got);
                    checkByte(got, expList[b], b);
                end
            end
        join
        checkLineIdle(bitClocks);
        hostRead(sdiRegPkg::statusAddr, word);
        checkWord(word, idleStatus, "status after capture");
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] word;
        logic [31:0] idleStatus;
        seed      = 35210;
        fifoDone  = 1'b1;
        addr      = '0;
        dataIn    = '0;
        byteWrite = '0;
        symEn     = 1'b0;
        iSample   = '0;
        qSample   = '0;
        idleStatus = '0;
        idleStatus[sdiRegPkg::statusEmptyBit] = 1'b1;
        vecFile = $fopen("verification/sdiVectors.txt", "r");
        if (vecFile == 0) stopRun("cannot open verification/sdiVectors.txt");
        repeat (resetCycles) @(posedge clk);
        fifoDone <= 1'b0;
        @(negedge clk);
        if (serialOut !== 1'b1) begin
            stopRun($sformatf("mismatch at %0t: serialOut not idle after reset", $time));
        end
        hostRead(sdiRegPkg::statusAddr, word);
        checkWord(word, idleStatus, "status after reset");
        hostRead(12'h00C, word);
        checkWord(word, sdiRegPkg::unmappedReadValue, "unmapped address");
        for (int c = 0; c < captures; c++) begin
            runCapture();
        end
        $fclose(vecFile);
        $display("Verification passed");
        $finish;
    end

endmodule

//--- verification/sdiVectors.txt
# capture header: divisor(hex) symbolCount(dec)
# symbol line: iSample qSample(18-bit hex) then bytes I-high I-low Q-high Q-low (hex)
0003 17
12301 32102 48 C0 C8 40
00013 33332 00 04 CC CC
21033 01230 84 0C 04 8C
30122 22221 C0 48 88 88
11110 10203 44 44 40 80
02201 31312 08 80 C4 C4
33003 00331 CC 00 00 CC
13020 21122 4C 08 84 48
20213 12123 80 84 48 48
03330 30001 0C CC C0 00
10032 02313 40 0C 08 C4
22310 13201 88 C4 4C 80
31203 23012 C4 80 8C 04
01122 11033 04 48 44 0C
32131 03210 C8 4C 0C 84
23232 30303 8C 8C C0 C0
11111 22222 44 44 88 88
0006 17
01230 32100 04 8C C8 40
10101 20202 40 40 80 80
33311 11133 CC C4 44 4C
02020 13131 08 08 4C 4C
21212 12121 84 84 48 48
30303 03030 C0 C0 0C 0C
12121 21212 48 48 84 84
00003 33330 00 00 CC CC
31310 13132 C4 C4 4C 4C
22001 00222 88 00 00 88
13313 31130 4C C4 C4 4C
20020 02201 80 08 08 80
01310 10131 04 C4 40 4C
32023 23102 C8 08 8C 40
11220 22113 44 88 88 44
03103 30130 0C 40 C0 4C
21021 12012 84 08 48 04
